/* project.f */
+incdir+include
hdl/dma_pkg.sv
hdl/mem_bank.sv
hdl/dma_fifo.sv
hdl/dma_apb_regs.sv
hdl/dma_read_engine.sv
hdl/dma_write_engine.sv
hdl/dma_xp.sv
hdl/dma_top.sv
tests/tb_clk_gen.sv
tests/dma_tb.sv

/* run.sh */
#!/bin/sh
# Builds the DMA testbench with Verilator and runs it into sim.log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module dma_tb \
  -Mdir obj_dir -o dma_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/dma_tb_sim > "$LOG" 2>&1
status=$?

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Simulation reported a failure, see $LOG."
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see $LOG."
  exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "Simulation ended without a result line, see $LOG."
  exit 1
fi
echo "Simulation passed."
exit 0

/* tests/dma_tb.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_tb;

  import dma_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int MEM_WORDS   = 1 << `DMA_ADDR_W;
  localparam int COPY_A_LEN  = 8;
  localparam int COPY_B_LEN  = 20;
  localparam int WORK_WORDS  = 3 * MEM_WORDS + COPY_A_LEN + COPY_B_LEN;
  localparam int WATCHDOG_NS = WORK_WORDS * 40 * CLK_PERIOD + 200 * CLK_PERIOD;

  localparam logic [`DMA_ADDR_W+2:0] REG_SRC  = 13'h000;
  localparam logic [`DMA_ADDR_W+2:0] REG_DST  = 13'h004;
  localparam logic [`DMA_ADDR_W+2:0] REG_LEN  = 13'h008;
  localparam logic [`DMA_ADDR_W+2:0] REG_CTRL = 13'h00c;

  typedef logic [`DMA_ADDR_W-1:0] word_t;

  typedef struct packed {
    logic done;
    logic busy;
  } status_t;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`DMA_ADDR_W+2:0] paddr;
  logic [`DMA_DATA_W-1:0] pwdata;
  logic [`DMA_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  mem_rsp_t               shadow [MEM_WORDS]; // Expected contents of both banks.
  integer                 seed;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dma_top DUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_data(input string test, input mem_rsp_t exp, input mem_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected 0x%08h, actual 0x%08h", test, exp, act));
    end
  endtask

  task automatic check_status(input string test, input status_t exp, input status_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected busy=%0b done=%0b, actual busy=%0b done=%0b",
                          test, exp.busy, exp.done, act.busy, act.done));
    end
  endtask

  task automatic check_err(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected pslverr=%0b, actual pslverr=%0b",
                          test, exp, act));
    end
  endtask

  task automatic init_inputs();
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
  endtask

  // One APB transfer; the access phase is stretched until pready.
  task automatic apb_access(input logic wr, input logic [`DMA_ADDR_W+2:0] addr,
                            input logic [`DMA_DATA_W-1:0] wdata,
                            output logic [`DMA_DATA_W-1:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    do begin
      @(negedge clk); // Outputs are sampled mid-cycle.
    end while (pready !== 1'b1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  function automatic logic [`DMA_ADDR_W+2:0] win_addr(input word_t word);
    return {1'b1, word, 2'b00};
  endfunction

  task automatic window_write(input word_t word, input mem_rsp_t data, output logic err);
    logic [`DMA_DATA_W-1:0] unused;
    apb_access(1'b1, win_addr(word), data, unused, err);
  endtask

  task automatic window_read(input word_t word, output mem_rsp_t data, output logic err);
    apb_access(1'b0, win_addr(word), '0, data, err);
  endtask

  task automatic read_status(output status_t st, output logic err);
    logic [`DMA_DATA_W-1:0] rdata;
    apb_access(1'b0, REG_CTRL, '0, rdata, err);
    st = status_t'(rdata[1:0]);
  endtask

  task automatic start_copy(input string test, input int src, input int dst, input int len,
                            output logic err);
    logic [`DMA_DATA_W-1:0] unused;
    apb_access(1'b1, REG_SRC, src, unused, err);
    check_err({test, " SRC write"}, 1'b0, err);
    apb_access(1'b1, REG_DST, dst, unused, err);
    check_err({test, " DST write"}, 1'b0, err);
    apb_access(1'b1, REG_LEN, len, unused, err);
    check_err({test, " LEN write"}, 1'b0, err);
    apb_access(1'b1, REG_CTRL, 32'd1, unused, err);
  endtask

  task automatic wait_done(input string test);
    status_t st;
    logic    err;
    do begin
      read_status(st, err);
      check_err({test, " status poll"}, 1'b0, err);
    end while (st.done !== 1'b1);
    check_status({test, " final status"}, '{done: 1'b1, busy: 1'b0}, st);
  endtask

  task automatic check_range(input string test, input int lo, input int hi);
    mem_rsp_t data;
    logic     err;
    for (int w = lo; w <= hi; w++) begin
      window_read(word_t'(w), data, err);
      check_err($sformatf("%s read err @%0d", test, w), 1'b0, err);
      check_data($sformatf("%s word %0d", test, w), shadow[w], data);
    end
  endtask

  task automatic copy_model(input int src, input int dst, input int len);
    for (int i = 0; i < len; i++) begin
      shadow[dst + i] = shadow[src + i];
    end
  endtask

  task automatic test_window();
    logic err;
    for (int w = 0; w < MEM_WORDS; w++) begin
      shadow[w] = $random(seed);
      window_write(word_t'(w), shadow[w], err);
      check_err($sformatf("window write err @%0d", w), 1'b0, err);
    end
    check_range("window readback", 0, MEM_WORDS - 1);
  endtask

  task automatic test_cross_bank();
    logic err;
    start_copy("cross bank", 16, 600, COPY_A_LEN, err);
    check_err("cross bank start", 1'b0, err);
    wait_done("cross bank");
    copy_model(16, 600, COPY_A_LEN);
    check_range("cross bank dst", 596, 600 + COPY_A_LEN + 3);
    check_range("cross bank src", 16, 16 + COPY_A_LEN - 1);
  endtask

  // The long copy keeps the engine busy while the illegal accesses are made.
  task automatic test_same_bank_busy();
    logic                   err;
    status_t                st;
    mem_rsp_t               data;
    logic [`DMA_DATA_W-1:0] unused;
    start_copy("same bank", 700, 760, COPY_B_LEN, err);
    check_err("same bank start", 1'b0, err);
    read_status(st, err);
    check_status("busy after start", '{done: 1'b0, busy: 1'b1}, st);
    apb_access(1'b1, REG_CTRL, 32'd1, unused, err);
    check_err("start while busy", 1'b1, err);
    window_read(word_t'(781), data, err);
    check_err("window read while busy", 1'b1, err);
    window_write(word_t'(781), 32'hdead_beef, err); // Outside the copy, so the copy cannot hide it.
    check_err("window write while busy", 1'b1, err);
    wait_done("same bank");
    copy_model(700, 760, COPY_B_LEN);
    check_range("same bank dst", 756, 760 + COPY_B_LEN + 3);
    check_range("same bank src", 700, 700 + COPY_B_LEN - 1);
  endtask

  task automatic test_bad_starts();
    logic    err;
    status_t st;
    start_copy("zero length", 100, 200, 0, err);
    check_err("zero length start", 1'b1, err);
    read_status(st, err);
    check_status("after zero length", '{done: 1'b1, busy: 1'b0}, st);
    start_copy("src wrap", 1020, 0, 8, err);
    check_err("src wrap start", 1'b1, err);
    read_status(st, err);
    check_status("after src wrap", '{done: 1'b1, busy: 1'b0}, st);
    start_copy("dst wrap", 0, 1020, 8, err);
    check_err("dst wrap start", 1'b1, err);
    read_status(st, err);
    check_status("after dst wrap", '{done: 1'b1, busy: 1'b0}, st);
    check_range("final memory", 0, MEM_WORDS - 1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout: the tests did not finish within the watchdog time.");
  end

  initial begin
    seed = 20;
    init_inputs();
    wait (rst_n === 1'b1);
    test_window();
    test_cross_bank();
    test_same_bank_busy();
    test_bad_starts();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, away from the flops' sampling edge.
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* hdl/dma_top.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`DMA_ADDR_W+2:0] paddr_i,
  input  logic [`DMA_DATA_W-1:0] pwdata_i,
  output logic [`DMA_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  import dma_pkg::*;

  dma_desc_t                                       desc;
  logic                                            start;
  logic                                            done;
  logic                                            push;
  logic                                            pop;
  logic                                            empty;
  logic [`DMA_DATA_W-1:0]                          push_data;
  logic [`DMA_DATA_W-1:0]                          pop_data;
  logic [`DMA_NUM_REQ-1:0]                         req_valid;
  mem_req_t [`DMA_NUM_REQ-1:0]                     req;
  logic [`DMA_NUM_REQ-1:0]                         req_gnt;
  logic [`DMA_NUM_REQ-1:0]                         rsp_valid;
  mem_rsp_t [`DMA_NUM_REQ-1:0]                     rsp;
  logic [`DMA_NUM_BANKS-1:0]                       bank_en;
  logic [`DMA_NUM_BANKS-1:0]                       bank_we;
  logic [`DMA_NUM_BANKS-1:0][`DMA_BANK_BIT-1:0]    bank_addr;
  logic [`DMA_NUM_BANKS-1:0][`DMA_DATA_W-1:0]      bank_wdata;
  logic [`DMA_NUM_BANKS-1:0][`DMA_DATA_W-1:0]      bank_rdata;

  dma_apb_regs i_regs (
    .clk_i, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .desc_o      (desc),
    .start_o     (start),
    .done_i      (done),
    .req_valid_o (req_valid[REQ_HOST]),
    .req_o       (req[REQ_HOST]),
    .req_gnt_i   (req_gnt[REQ_HOST]),
    .rsp_valid_i (rsp_valid[REQ_HOST]),
    .rsp_i       (rsp[REQ_HOST])
  );

  dma_read_engine i_rd (
    .clk_i, .rst_n_i,
    .desc_i      (desc),
    .start_i     (start),
    .req_valid_o (req_valid[REQ_RD]),
    .req_o       (req[REQ_RD]),
    .req_gnt_i   (req_gnt[REQ_RD]),
    .rsp_valid_i (rsp_valid[REQ_RD]),
    .rsp_i       (rsp[REQ_RD]),
    .push_o      (push),
    .push_data_o (push_data),
    .pop_seen_i  (pop) // Each pop returns one credit.
  );

  dma_fifo i_fifo (
    .clk_i, .rst_n_i,
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .empty_o     (empty)
  );

  dma_write_engine i_wr (
    .clk_i, .rst_n_i,
    .desc_i      (desc),
    .start_i     (start),
    .empty_i     (empty),
    .pop_data_i  (pop_data),
    .pop_o       (pop),
    .req_valid_o (req_valid[REQ_WR]),
    .req_o       (req[REQ_WR]),
    .req_gnt_i   (req_gnt[REQ_WR]),
    .done_o      (done)
  );

  dma_xp i_xp (
    .clk_i, .rst_n_i,
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_gnt_o    (req_gnt),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .bank_en_o    (bank_en),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_rdata_i (bank_rdata)
  );

  for (genvar b = 0; b < `DMA_NUM_BANKS; b++) begin : gen_bank
    mem_bank i_bank (
      .clk_i,
      .en_i    (bank_en[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_addr[b]),
      .wdata_i (bank_wdata[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

/* hdl/dma_xp.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_xp (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [`DMA_NUM_REQ-1:0]                           req_valid_i,
  input  dma_pkg::mem_req_t [`DMA_NUM_REQ-1:0]              req_i,
  output logic [`DMA_NUM_REQ-1:0]                           req_gnt_o,
  output logic [`DMA_NUM_REQ-1:0]                           rsp_valid_o,
  output dma_pkg::mem_rsp_t [`DMA_NUM_REQ-1:0]              rsp_o,
  output logic [`DMA_NUM_BANKS-1:0]                         bank_en_o,
  output logic [`DMA_NUM_BANKS-1:0]                         bank_we_o,
  output logic [`DMA_NUM_BANKS-1:0][`DMA_BANK_BIT-1:0]      bank_addr_o,
  output logic [`DMA_NUM_BANKS-1:0][`DMA_DATA_W-1:0]        bank_wdata_o,
  input  logic [`DMA_NUM_BANKS-1:0][`DMA_DATA_W-1:0]        bank_rdata_i
);

  import dma_pkg::*;

  req_idx_t rr_q      [`DMA_NUM_BANKS];
  req_idx_t win_idx   [`DMA_NUM_BANKS];
  req_idx_t rd_tag_q  [`DMA_NUM_BANKS];
  logic     win_vld   [`DMA_NUM_BANKS];
  logic     rd_pend_q [`DMA_NUM_BANKS];

  // Scanning from the far end lets the requester nearest the pointer win.
  always_comb begin : arb
    int unsigned idx;
    for (int b = 0; b < `DMA_NUM_BANKS; b++) begin
      win_vld[b] = 1'b0;
      win_idx[b] = REQ_HOST;
      for (int off = `DMA_NUM_REQ - 1; off >= 0; off--) begin
        idx = (int'(rr_q[b]) + off) % `DMA_NUM_REQ;
        if (req_valid_i[idx] && (int'(bank_sel(req_i[idx])) == b)) begin
          win_vld[b] = 1'b1;
          win_idx[b] = req_idx_t'(idx);
        end
      end
      bank_en_o[b]    = win_vld[b];
      bank_we_o[b]    = win_vld[b] && req_i[win_idx[b]].we;
      bank_addr_o[b]  = req_i[win_idx[b]].addr[`DMA_BANK_BIT-1:0];
      bank_wdata_o[b] = req_i[win_idx[b]].wdata;
    end
  end

  always_comb begin : route
    for (int r = 0; r < `DMA_NUM_REQ; r++) begin
      req_gnt_o[r]   = 1'b0;
      rsp_valid_o[r] = 1'b0;
      rsp_o[r]       = '0;
      for (int b = 0; b < `DMA_NUM_BANKS; b++) begin
        if (win_vld[b] && (win_idx[b] == req_idx_t'(r))) begin
          req_gnt_o[r] = 1'b1;
        end
        if (rd_pend_q[b] && (rd_tag_q[b] == req_idx_t'(r))) begin
          rsp_valid_o[r] = 1'b1;
          rsp_o[r]       = bank_rdata_i[b];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < `DMA_NUM_BANKS; b++) begin
        rr_q[b]      <= REQ_HOST;
        rd_pend_q[b] <= 1'b0;
      end
    end else begin
      for (int b = 0; b < `DMA_NUM_BANKS; b++) begin
        rd_pend_q[b] <= win_vld[b] && !bank_we_o[b];
        if (win_vld[b]) begin
          rr_q[b] <= next_req(win_idx[b]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `DMA_NUM_BANKS; b++) begin
      rd_tag_q[b] <= win_idx[b];
    end
  end

  for (genvar b = 0; b < `DMA_NUM_BANKS; b++) begin : gen_chk
    logic [`DMA_NUM_REQ-1:0] bank_gnt;
    for (genvar r = 0; r < `DMA_NUM_REQ; r++) begin : gen_gnt
      assign bank_gnt[r] = req_gnt_o[r] && (int'(bank_sel(req_i[r])) == b);
    end
    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(bank_gnt));
  end

endmodule

/* hdl/dma_write_engine.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_write_engine (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  dma_pkg::dma_desc_t     desc_i,
  input  logic                   start_i,
  input  logic                   empty_i,
  input  logic [`DMA_DATA_W-1:0] pop_data_i,
  output logic                   pop_o,
  output logic                   req_valid_o,
  output dma_pkg::mem_req_t      req_o,
  input  logic                   req_gnt_i,
  output logic                   done_o
);

  logic [`DMA_ADDR_W-1:0] addr_q;
  logic [`DMA_ADDR_W-1:0] remain_q;
  logic                   done_q;
  logic                   issue;

  // The FIFO head is offered as a write to the next destination word.
  assign req_valid_o = (remain_q != '0) && !empty_i;
  assign req_o       = '{addr: addr_q, we: 1'b1, wdata: pop_data_i};
  assign issue       = req_valid_o && req_gnt_i;
  assign pop_o       = issue;
  assign done_o      = done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q   <= '0;
      remain_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= issue && (remain_q == `DMA_ADDR_W'(1)); // Last word written.
      if (start_i) begin
        addr_q   <= desc_i.dst;
        remain_q <= desc_i.len;
      end else if (issue) begin
        addr_q   <= addr_q + 1'b1;
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  // A new transfer may only start once the previous one has drained.
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> remain_q == '0 && empty_i);

endmodule

/* hdl/dma_read_engine.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_read_engine (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  dma_pkg::dma_desc_t     desc_i,
  input  logic                   start_i,
  output logic                   req_valid_o,
  output dma_pkg::mem_req_t      req_o,
  input  logic                   req_gnt_i,
  input  logic                   rsp_valid_i,
  input  dma_pkg::mem_rsp_t      rsp_i,
  output logic                   push_o,
  output logic [`DMA_DATA_W-1:0] push_data_o,
  input  logic                   pop_seen_i
);

  localparam int unsigned CRED_W = $clog2(`DMA_FIFO_DEPTH + 1);

  logic [`DMA_ADDR_W-1:0] addr_q;
  logic [`DMA_ADDR_W-1:0] remain_q;
  logic [CRED_W-1:0]      credit_q;
  logic                   issue;

  // Reads in flight plus words in the FIFO never exceed its depth.
  assign req_valid_o = (remain_q != '0) && (credit_q < CRED_W'(`DMA_FIFO_DEPTH));
  assign req_o       = '{addr: addr_q, we: 1'b0, wdata: '0};
  assign issue       = req_valid_o && req_gnt_i;

  assign push_o      = rsp_valid_i; // Every response goes straight into the FIFO.
  assign push_data_o = rsp_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q   <= '0;
      remain_q <= '0;
      credit_q <= '0;
    end else begin
      if (start_i) begin
        addr_q   <= desc_i.src;
        remain_q <= desc_i.len;
      end else if (issue) begin
        addr_q   <= addr_q + 1'b1;
        remain_q <= remain_q - 1'b1;
      end
      case ({issue, pop_seen_i})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // A pushed word must belong to a read that still holds a credit.
  a_push_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_o |-> credit_q != '0);

endmodule

/* hdl/dma_apb_regs.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_apb_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`DMA_ADDR_W+2:0] paddr_i,
  input  logic [`DMA_DATA_W-1:0] pwdata_i,
  output logic [`DMA_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output dma_pkg::dma_desc_t     desc_o,
  output logic                   start_o,
  input  logic                   done_i,
  output logic                   req_valid_o,
  output dma_pkg::mem_req_t      req_o,
  input  logic                   req_gnt_i,
  input  logic                   rsp_valid_i,
  input  dma_pkg::mem_rsp_t      rsp_i
);

  import dma_pkg::*;

  localparam logic [`DMA_ADDR_W:0] WORDS = {1'b1, {`DMA_ADDR_W{1'b0}}};

  dma_desc_t              desc_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   start_q;
  logic                   win_rd_q;
  logic                   acc;
  logic                   win_sel;
  logic                   reg_acc;
  logic                   win_acc;
  logic                   win_err;
  logic                   start_wr;
  logic                   start_err;
  logic [1:0]             reg_sel;
  logic [`DMA_ADDR_W:0]   src_end;
  logic [`DMA_ADDR_W:0]   dst_end;
  logic [`DMA_DATA_W-1:0] reg_rdata;

  assign acc     = psel_i && penable_i; // APB access phase.
  assign win_sel = paddr_i[`DMA_ADDR_W+2];
  assign reg_acc = acc && !win_sel;
  assign win_acc = acc && win_sel && !busy_q;
  assign win_err = acc && win_sel && busy_q;
  assign reg_sel = paddr_i[3:2];

  assign src_end   = {1'b0, desc_q.src} + {1'b0, desc_q.len};
  assign dst_end   = {1'b0, desc_q.dst} + {1'b0, desc_q.len};
  assign start_wr  = reg_acc && pwrite_i && (reg_sel == 2'd3) && pwdata_i[0];
  assign start_err = busy_q || (desc_q.len == '0) || (src_end > WORDS) || (dst_end > WORDS);

  assign req_valid_o = win_acc && !win_rd_q; // Dropped once a read is granted.
  assign req_o       = '{addr: paddr_i[`DMA_ADDR_W+1:2], we: pwrite_i, wdata: pwdata_i};

  assign pready_o  = reg_acc || win_err || (req_valid_o && req_gnt_i && pwrite_i) ||
                     (win_rd_q && rsp_valid_i);
  assign pslverr_o = win_err || (start_wr && start_err);

  always_comb begin
    case (reg_sel)
      2'd0:    reg_rdata = {{(`DMA_DATA_W-`DMA_ADDR_W){1'b0}}, desc_q.src};
      2'd1:    reg_rdata = {{(`DMA_DATA_W-`DMA_ADDR_W){1'b0}}, desc_q.dst};
      2'd2:    reg_rdata = {{(`DMA_DATA_W-`DMA_ADDR_W){1'b0}}, desc_q.len};
      default: reg_rdata = {{(`DMA_DATA_W-2){1'b0}}, done_q, busy_q};
    endcase
  end

  assign prdata_o = win_sel ? rsp_i : reg_rdata;
  assign desc_o   = desc_q;
  assign start_o  = start_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      desc_q   <= '0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      start_q  <= 1'b0;
      win_rd_q <= 1'b0;
    end else begin
      start_q  <= start_wr && !start_err;
      win_rd_q <= req_valid_o && req_gnt_i && !pwrite_i; // Data returns next cycle.
      if (reg_acc && pwrite_i) begin
        case (reg_sel)
          2'd0:    desc_q.src <= pwdata_i[`DMA_ADDR_W-1:0];
          2'd1:    desc_q.dst <= pwdata_i[`DMA_ADDR_W-1:0];
          2'd2:    desc_q.len <= pwdata_i[`DMA_ADDR_W-1:0];
          default: ;
        endcase
      end
      if (start_wr && !start_err) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // The APB master must hold the window address and data until the fabric grants.
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o && !req_gnt_i |=> req_valid_o && $stable(req_o));

endmodule

/* hdl/dma_fifo.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module dma_fifo (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  logic [`DMA_DATA_W-1:0] push_data_i,
  input  logic                   pop_i,
  output logic [`DMA_DATA_W-1:0] pop_data_o,
  output logic                   empty_o
);

  localparam int unsigned PTR_W = $clog2(`DMA_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`DMA_FIFO_DEPTH + 1);

  logic [`DMA_DATA_W-1:0] mem [`DMA_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   full;

  assign empty_o    = (count_q == '0);
  assign full       = (count_q == CNT_W'(`DMA_FIFO_DEPTH));
  assign pop_data_o = mem[rd_ptr_q]; // Show-ahead head word.

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

/* hdl/mem_bank.sv */
`timescale 1ns/10ps
`include "dma_cfg.svh"

module mem_bank (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [`DMA_BANK_BIT-1:0] addr_i,
  input  logic [`DMA_DATA_W-1:0]   wdata_i,
  output logic [`DMA_DATA_W-1:0]   rdata_o
);

  localparam int unsigned WORDS = 1 << `DMA_BANK_BIT;

  logic [`DMA_DATA_W-1:0] mem [WORDS];
  logic [`DMA_DATA_W-1:0] rdata_q;

  // Read data follows the enable by one cycle; a write returns the old word.
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hdl/dma_pkg.sv */
`include "dma_cfg.svh"

package dma_pkg;

  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] addr;
    logic                   we;
    logic [`DMA_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef logic [`DMA_DATA_W-1:0] mem_rsp_t;

  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] src;
    logic [`DMA_ADDR_W-1:0] dst;
    logic [`DMA_ADDR_W-1:0] len;
  } dma_desc_t;

  // Requester slots on the crosspoint.
  typedef enum logic [1:0] {
    REQ_HOST = 2'd0,
    REQ_RD   = 2'd1,
    REQ_WR   = 2'd2
  } req_idx_t;

  typedef logic [$clog2(`DMA_NUM_BANKS)-1:0] bank_idx_t;

  function automatic bank_idx_t bank_sel(mem_req_t req);
    return req.addr[`DMA_BANK_BIT +: $clog2(`DMA_NUM_BANKS)];
  endfunction

  // Round-robin successor of a requester index.
  function automatic req_idx_t next_req(req_idx_t idx);
    if (int'(idx) == `DMA_NUM_REQ - 1) begin
      return REQ_HOST;
    end
    return req_idx_t'(int'(idx) + 1);
  endfunction

endpackage

/* include/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define DMA_ADDR_W     10
`define DMA_DATA_W     32

// Bank 0 holds the lower half of the word space and bank 1 the upper half.
`define DMA_BANK_BIT   9
`define DMA_NUM_BANKS  2

`define DMA_NUM_REQ    3
`define DMA_FIFO_DEPTH 4

`endif
